// ==== Bender.yml ====
package:
  name: fm_mmr

sources:
  - hw/fm_pkg.sv
  - hw/fm_op_ram.sv
  - hw/fm_ch_shreg.sv
  - hw/fm_keyon.sv
  - hw/fm_alg_route.sv
  - hw/fm_slot_regs.sv
  - hw/fm_mmr.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_fm_mmr.sv

// ==== bench/fm_tb_model.svh ====
`ifndef FM_TB_MODEL_SVH
`define FM_TB_MODEL_SVH

// operator words by {op, ch}, channel state by ch
logic [OP_WORD_W-1:0] exp_op [32];
logic [5:0] exp_lat [8];
fnum_t exp_fnum [8];
block_t exp_block [8];
logic [2:0] exp_fb [8];
alg_t exp_alg [8];
logic [1:0] exp_rl [8];
logic [1:0] exp_ams [8];
logic [2:0] exp_pms [8];
// key bits S1 S2 S3 S4, as in the 0x28 write
logic [3:0] exp_key [8];

// channel 3 effect registers, indexed by operator position
logic [5:0] eff_lat;
fnum_t eff_fnum [4];
block_t eff_block [4];
logic exp_effect;
logic exp_csm;

// position in the lap to channel index, 3 is skipped
function automatic ch_idx_t chan_of(input int pos);
	return (pos < 3) ? ch_idx_t'(pos) : ch_idx_t'(pos + 1);
endfunction

// A8 is S3, A9 is S1, AA is S2
function automatic op_idx_t eff_pos(input logic [1:0] lo);
	case (lo)
		2'd0: return 2'd1;
		2'd1: return 2'd0;
		default: return 2'd2;
	endcase
endfunction

function automatic logic key_of(input logic [3:0] keys, input op_idx_t op);
	case (op)
		2'd0: return keys[0];
		2'd1: return keys[2];
		2'd2: return keys[1];
		default: return keys[3];
	endcase
endfunction

// operator word after a write to field group grp (0x3 to 0x9)
function automatic logic [OP_WORD_W-1:0] op_word_after(input logic [OP_WORD_W-1:0] word,
		input logic [3:0] grp, input reg_byte_t d);
	logic [6:0] tl_f;
	logic [2:0] dt1_f;
	logic [3:0] mul_f;
	logic [1:0] ks_f;
	logic [4:0] ar_f;
	logic amsen_f;
	logic [4:0] d1r_f;
	logic [4:0] d2r_f;
	logic [3:0] d1l_f;
	logic [3:0] rr_f;
	logic ssg_en_f;
	logic [2:0] ssg_eg_f;
	{tl_f, dt1_f, mul_f, ks_f, ar_f, amsen_f, d1r_f, d2r_f, d1l_f, rr_f,
		ssg_en_f, ssg_eg_f} = word;
	case (grp)
		4'h3: begin
			dt1_f = d[6:4];
			mul_f = d[3:0];
		end
		4'h4: tl_f = d[6:0];
		4'h5: begin
			ks_f = d[7:6];
			ar_f = d[4:0];
		end
		4'h6: begin
			amsen_f = d[7];
			d1r_f = d[4:0];
		end
		4'h7: d2r_f = d[4:0];
		4'h8: begin
			d1l_f = d[7:4];
			rr_f = d[3:0];
		end
		default: begin
			ssg_en_f = d[3];
			ssg_eg_f = d[2:0];
		end
	endcase
	return {tl_f, dt1_f, mul_f, ks_f, ar_f, amsen_f, d1r_f, d2r_f, d1l_f, rr_f,
		ssg_en_f, ssg_eg_f};
endfunction

// {use_prev1, use_prev2, use_prevprev1, use_internal_x, use_internal_y}
function automatic logic [4:0] route_flags(input alg_t a, input op_idx_t op);
	logic [4:0] f;
	f = '0;
	case (op)
		2'd2: f[4] = (a == 0) || (a == 3) || (a == 4) || (a == 5) || (a == 6);
		2'd1: begin
			f[2] = (a == 1) || (a == 5);
			f[3] = (a == 0) || (a == 1) || (a == 2);
		end
		2'd3: begin
			f[4] = a <= 4;
			f[1] = a == 3;
			f[0] = (a == 2) || (a == 5);
		end
		default: ;
	endcase
	return f;
endfunction

// {block, fnum} seen at a slot
function automatic logic [13:0] expected_freq(input op_idx_t op, input ch_idx_t ch);
	if (exp_effect && ch == 3'd2 && op != 2'd3) begin
		return {eff_block[op], eff_fnum[op]};
	end
	return {exp_block[ch], exp_fnum[ch]};
endfunction

task automatic model_reset();
	for (int i = 0; i < 32; i++) begin
		exp_op[i] = '0;
	end
	for (int c = 0; c < 8; c++) begin
		exp_lat[c] = '0;
		exp_fnum[c] = '0;
		exp_block[c] = '0;
		exp_fb[c] = '0;
		exp_alg[c] = '0;
		exp_rl[c] = 2'b11;
		exp_ams[c] = '0;
		exp_pms[c] = '0;
		exp_key[c] = '0;
	end
	for (int p = 0; p < 4; p++) begin
		eff_fnum[p] = '0;
		eff_block[p] = '0;
	end
	eff_lat = '0;
	exp_effect = 1'b0;
	exp_csm = 1'b0;
endtask

task automatic model_write(input logic part, input reg_byte_t addr, input reg_byte_t d);
	ch_idx_t ch;
	slot_t s;
	op_idx_t p;
	ch = {part, addr[1:0]};
	s = {addr[3:2], ch};
	p = eff_pos(addr[1:0]);
	if (addr >= 8'h30 && addr <= 8'h9F) begin
		if (addr[1:0] != 2'd3) begin
			exp_op[s] = op_word_after(exp_op[s], addr[7:4], d);
		end
	end else if (addr >= 8'hA0 && addr <= 8'hA2) begin
		exp_fnum[ch] = {exp_lat[ch][2:0], d};
		exp_block[ch] = exp_lat[ch][5:3];
	end else if (addr >= 8'hA4 && addr <= 8'hA6) begin
		exp_lat[ch] = d[5:0];
	end else if (!part && addr >= 8'hA8 && addr <= 8'hAA) begin
		eff_fnum[p] = {eff_lat[2:0], d};
		eff_block[p] = eff_lat[5:3];
	end else if (!part && addr >= 8'hAC && addr <= 8'hAE) begin
		eff_lat = d[5:0];
	end else if (addr >= 8'hB0 && addr <= 8'hB2) begin
		exp_fb[ch] = d[5:3];
		exp_alg[ch] = d[2:0];
	end else if (addr >= 8'hB4 && addr <= 8'hB6) begin
		exp_rl[ch] = d[7:6];
		exp_ams[ch] = d[5:4];
		exp_pms[ch] = d[2:0];
	end else if (!part && addr == 8'h28 && d[1:0] != 2'd3) begin
		exp_key[d[2:0]] = d[7:4];
	end else if (!part && addr == 8'h27) begin
		exp_effect = d[7] | d[6];
		exp_csm = d[7];
	end
endtask

`endif

// ==== bench/tb_fm_mmr.sv ====
`default_nettype none

module tb_fm_mmr import fm_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// data writes per test, for the timeout
	localparam int N_OP_WRITES = 12;
	localparam int N_WRITES = N_OP_WRITES + 2 + 7 + 10 + 6 + 8;
	localparam int TIMEOUT_CYCLES = N_WRITES * 40 * NUM_SLOTS;

	logic clk = 1'b0;
	logic rst;
	logic clk_en;
	logic cpu_wr;
	logic cpu_a0;
	logic cpu_part;
	reg_byte_t cpu_din;
	logic overflow_a;
	logic busy, zero, ch6op;
	logic s1_enters, s2_enters, s3_enters, s4_enters;
	fnum_t fnum;
	block_t block;
	logic [1:0] rl;
	logic [2:0] fb;
	alg_t alg;
	logic [2:0] pms;
	logic [1:0] ams;
	logic amsen;
	logic [2:0] dt1;
	logic [3:0] mul;
	logic [6:0] tl;
	logic [1:0] ks;
	logic [4:0] ar, d1r, d2r;
	logic [3:0] rr;
	logic [3:0] d1l;
	logic ssg_en;
	logic [2:0] ssg_eg;
	logic keyon;
	logic use_prev1, use_prev2, use_prevprev1, use_internal_x, use_internal_y;

	logic en_force;
	int slot_cnt;
	int csm_left;
	int checks_wanted = 0;
	int checks_done = 0;
	int n_checks = 0;
	int n_errors = 0;
	int cycle_cnt = 0;

	`include "fm_tb_model.svh"

	fm_mmr dut (
		.*
	);

	always #2 clk = ~clk;

	// about three ticks in four, forced high for CPU strobes
	always @(posedge clk) begin
		clk_en <= en_force || ($urandom % 4 != 0);
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("[FAIL] %0t: %s is %0h, expected %0h", $time, name, got, want);
		end
	endtask

	task automatic compare_slot(input int idx);
		op_idx_t op;
		ch_idx_t ch;
		slot_t s;
		logic [6:0] e_tl;
		logic [2:0] e_dt1;
		logic [3:0] e_mul;
		logic [1:0] e_ks;
		logic [4:0] e_ar;
		logic e_amsen;
		logic [4:0] e_d1r;
		logic [4:0] e_d2r;
		logic [3:0] e_d1l;
		logic [3:0] e_rr;
		logic e_ssg_en;
		logic [2:0] e_ssg_eg;
		logic e_key;
		string at;
		op = op_idx_t'(idx / 6);
		ch = chan_of(idx % 6);
		s = {op, ch};
		at = $sformatf("op%0d ch%0d", op, ch);
		{e_tl, e_dt1, e_mul, e_ks, e_ar, e_amsen, e_d1r, e_d2r, e_d1l, e_rr,
			e_ssg_en, e_ssg_eg} = exp_op[s];
		e_key = key_of(exp_key[ch], op) | (csm_left != 0 && ch == 3'd2);
		check_value({at, " busy"}, busy, 0);
		check_value({at, " zero"}, zero, idx == 0);
		check_value({at, " ch6op"}, ch6op, ch == 3'd6);
		check_value({at, " enters"}, {s1_enters, s2_enters, s3_enters, s4_enters},
			{op == 2'd0, op == 2'd2, op == 2'd1, op == 2'd3});
		check_value({at, " block/fnum"}, {block, fnum}, expected_freq(op, ch));
		check_value({at, " rl"}, rl, exp_rl[ch]);
		check_value({at, " fb"}, fb, exp_fb[ch]);
		check_value({at, " alg"}, alg, exp_alg[ch]);
		check_value({at, " ams"}, ams, exp_ams[ch]);
		check_value({at, " pms"}, pms, exp_pms[ch]);
		check_value({at, " tl"}, tl, e_tl);
		check_value({at, " dt1"}, dt1, e_dt1);
		check_value({at, " mul"}, mul, e_mul);
		check_value({at, " ks"}, ks, e_ks);
		check_value({at, " ar"}, ar, e_ar);
		check_value({at, " amsen"}, amsen, e_amsen);
		check_value({at, " d1r"}, d1r, e_d1r);
		check_value({at, " d2r"}, d2r, e_d2r);
		check_value({at, " d1l"}, d1l, e_d1l);
		check_value({at, " rr"}, rr, e_rr);
		check_value({at, " ssg_en"}, ssg_en, e_ssg_en);
		check_value({at, " ssg_eg"}, ssg_eg, e_ssg_eg);
		check_value({at, " keyon"}, keyon, e_key);
		check_value({at, " use flags"}, {use_prev1, use_prev2, use_prevprev1,
			use_internal_x, use_internal_y}, route_flags(exp_alg[ch], op));
	endtask

	// slot count follows the DUT from reset, one step per tick
	always @(posedge clk) begin
		if (rst) begin
			slot_cnt <= 0;
			csm_left <= 0;
		end else if (clk_en) begin
			if (checks_done != checks_wanted) begin
				compare_slot(slot_cnt);
				checks_done <= checks_done + 1;
			end
			// forced key-on covers the lap after the overflow tick
			if (exp_csm && overflow_a) begin
				csm_left <= NUM_SLOTS;
			end else if (csm_left != 0) begin
				csm_left <= csm_left - 1;
			end
			slot_cnt <= (slot_cnt == NUM_SLOTS - 1) ? 0 : slot_cnt + 1;
		end
	end

	// one CPU strobe, on a cycle where clk_en is high
	task automatic cpu_write(input logic part, input logic a0, input reg_byte_t d);
		en_force <= 1'b1;
		@(posedge clk);
		cpu_wr <= 1'b1;
		cpu_a0 <= a0;
		cpu_part <= part;
		cpu_din <= d;
		en_force <= 1'b0;
		@(posedge clk);
		cpu_wr <= 1'b0;
	endtask

	task automatic wait_idle();
		@(posedge clk);
		while (busy !== 1'b0) begin
			@(posedge clk);
		end
	endtask

	task automatic check_lap();
		checks_wanted <= checks_wanted + NUM_SLOTS;
		@(posedge clk);
		while (checks_done != checks_wanted) begin
			@(posedge clk);
		end
	endtask

	task automatic reg_write(input logic part, input reg_byte_t addr, input reg_byte_t d);
		cpu_write(part, 1'b0, addr);
		cpu_write(part, 1'b1, d);
		model_write(part, addr, d);
		wait_idle();
		check_lap();
	endtask

	task automatic pulse_overflow();
		en_force <= 1'b1;
		@(posedge clk);
		overflow_a <= 1'b1;
		en_force <= 1'b0;
		@(posedge clk);
		overflow_a <= 1'b0;
	endtask

	initial begin
		reg_byte_t addr;
		void'($urandom(32'hd176));
		rst <= 1'b1;
		clk_en <= 1'b0;
		cpu_wr <= 1'b0;
		cpu_a0 <= 1'b0;
		cpu_part <= 1'b0;
		cpu_din <= '0;
		overflow_a <= 1'b0;
		en_force <= 1'b0;
		model_reset();
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		// reset values after the init lap
		wait_idle();
		check_lap();
		check_lap();

		// operator fields on random slots
		for (int i = 0; i < N_OP_WRITES; i++) begin
			addr = {4'(3 + $urandom % 7), 2'($urandom % 4), 2'($urandom % 3)};
			reg_write(1'($urandom % 2), addr, reg_byte_t'($urandom % 256));
		end
		// channel low bits 3 must be ignored
		reg_write(1'b0, 8'h47, 8'h5a);
		reg_write(1'b1, 8'h83, 8'hc3);

		// high byte waits for the low byte
		reg_write(1'b1, 8'hA5, 8'h2d);
		reg_write(1'b1, 8'hA1, 8'h9e);
		reg_write(1'b0, 8'hA4, 8'h13);
		reg_write(1'b0, 8'hA0, 8'h47);
		reg_write(1'b1, 8'hB0, 8'h2b);
		reg_write(1'b0, 8'hB5, 8'h75);
		reg_write(1'b1, 8'hB6, 8'h83);

		// channel 3 effect frequencies
		reg_write(1'b0, 8'hA6, 8'h22);
		reg_write(1'b0, 8'hA2, 8'h80);
		reg_write(1'b0, 8'hAD, 8'h0c);
		reg_write(1'b0, 8'hA9, 8'h11);
		reg_write(1'b0, 8'hAE, 8'h35);
		reg_write(1'b0, 8'hAA, 8'hf0);
		reg_write(1'b0, 8'hAC, 8'h1f);
		reg_write(1'b0, 8'hA8, 8'h6b);
		reg_write(1'b0, 8'h27, 8'h40);
		reg_write(1'b0, 8'h27, 8'h00);

		// key-on writes, then composite sine
		reg_write(1'b0, 8'h28, 8'hf1);
		reg_write(1'b0, 8'h28, 8'h56);
		reg_write(1'b0, 8'h28, 8'h34);
		reg_write(1'b0, 8'h28, 8'h01);
		reg_write(1'b0, 8'h27, 8'h80);
		pulse_overflow();
		check_lap();
		check_lap();
		reg_write(1'b0, 8'h27, 8'h00);

		// every algorithm once
		for (int a = 0; a < 8; a++) begin
			addr = {6'b1011_00, 2'(a % 3)};
			reg_write(1'(a / 3 % 2), addr, reg_byte_t'({2'b00, 3'(a), 3'(a)}));
		end

		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0 && n_checks > 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/fm_alg_route.sv ====
`default_nettype none

module fm_alg_route import fm_pkg::*; (
	input  alg_t alg,
	input  logic s1_enters,
	input  logic s2_enters,
	input  logic s3_enters,
	input  logic s4_enters,
	output logic use_prev1,
	output logic use_prev2,
	output logic use_prevprev1,
	output logic use_internal_x,
	output logic use_internal_y
);

	logic [7:0] a;

	// one-hot algorithm
	assign a = 8'b1 << alg;

	// S1 only ever takes feedback, nothing from here
	always_comb begin
		use_prev1 = 1'b0;
		use_prev2 = 1'b0;
		use_prevprev1 = 1'b0;
		use_internal_x = 1'b0;
		use_internal_y = 1'b0;
		if (s2_enters) begin
			use_prev1 = a[0] | a[3] | a[4] | a[5] | a[6];
		end
		if (s3_enters) begin
			use_prevprev1 = a[1] | a[5];
			use_prev2 = a[0] | a[1] | a[2];
		end
		if (s4_enters) begin
			use_prev1 = a[0] | a[1] | a[2] | a[3] | a[4];
			use_internal_x = a[3];
			use_internal_y = a[2] | a[5];
		end
	end

endmodule

`default_nettype wire

// ==== hw/fm_ch_shreg.sv ====
`default_nettype none

module fm_ch_shreg #(
	parameter int width = 1,
	parameter int stages = 2,
	parameter logic [width-1:0] rst_val = '0
) (
	input  logic             clk,
	input  logic             clk_en,
	input  logic             rst,
	input  logic [width-1:0] din,
	output logic [width-1:0] dout
);

	logic [width-1:0] sr [stages];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < stages; i++) begin
				sr[i] <= rst_val;
			end
		end else if (clk_en) begin
			sr[0] <= din;
			for (int i = 1; i < stages; i++) begin
				sr[i] <= sr[i-1];
			end
		end
	end

	// oldest stage comes back around to its own channel
	assign dout = sr[stages-1];

endmodule

`default_nettype wire

// ==== hw/fm_keyon.sv ====
`default_nettype none

module fm_keyon import fm_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       clk_en,
	input  logic [3:0] keyon_op,
	input  ch_idx_t    keyon_ch,
	input  op_idx_t    cur_op,
	input  ch_idx_t    cur_ch,
	input  logic       up_keyon,
	input  logic       csm,
	input  logic       overflow_a,
	output logic       keyon
);

	logic [NUM_SLOTS-1:0] ring;
	logic key_bit;
	logic key_d;
	logic csm_on;
	slot_t csm_slot;

	// write bits are S1 S2 S3 S4, slots run S1 S3 S2 S4
	always_comb begin
		case (cur_op)
			2'd0: key_bit = keyon_op[0];
			2'd1: key_bit = keyon_op[2];
			2'd2: key_bit = keyon_op[1];
			default: key_bit = keyon_op[3];
		endcase
	end

	assign key_d = (up_keyon && keyon_ch == cur_ch) ? key_bit : ring[NUM_SLOTS-1];

	// composite sine forces channel 2 on without touching the stored state
	assign keyon = key_d | (csm_on && cur_ch == 3'd2);

	always_ff @(posedge clk) begin
		if (rst) begin
			ring <= '0;
			csm_on <= 1'b0;
		end else if (clk_en) begin
			ring <= {ring[NUM_SLOTS-2:0], key_d};
			if (csm && overflow_a) begin
				csm_on <= 1'b1;
			end else if (csm_on && {cur_op, cur_ch} == csm_slot) begin
				csm_on <= 1'b0;
			end
		end
	end

	// lap start for the forced key-on
	always_ff @(posedge clk) begin
		if (clk_en && csm && overflow_a) begin
			csm_slot <= {cur_op, cur_ch};
		end
	end

endmodule

`default_nettype wire

// ==== hw/fm_mmr.sv ====
`default_nettype none

module fm_mmr import fm_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      clk_en,
	input  logic      cpu_wr,
	input  logic      cpu_a0,
	input  logic      cpu_part,
	input  reg_byte_t cpu_din,
	input  logic      overflow_a,
	output logic      busy,
	output logic      zero,
	output logic      ch6op,
	output logic      s1_enters,
	output logic      s2_enters,
	output logic      s3_enters,
	output logic      s4_enters,
	output fnum_t     fnum,
	output block_t    block,
	output logic [1:0] rl,
	output logic [2:0] fb,
	output alg_t      alg,
	output logic [2:0] pms,
	output logic [1:0] ams,
	output logic      amsen,
	output logic [2:0] dt1,
	output logic [3:0] mul,
	output logic [6:0] tl,
	output logic [1:0] ks,
	output logic [4:0] ar,
	output logic [4:0] d1r,
	output logic [4:0] d2r,
	output logic [3:0] rr,
	output logic [3:0] d1l,
	output logic      ssg_en,
	output logic [2:0] ssg_eg,
	output logic      keyon,
	output logic      use_prev1,
	output logic      use_prev2,
	output logic      use_prevprev1,
	output logic      use_internal_x,
	output logic      use_internal_y
);

	reg_byte_t addr_q;
	logic part_q;
	logic wr_data;
	logic lo_ok;
	logic in_op;
	logic [11:0] up_next, up_q;
	reg_byte_t up_din;
	ch_idx_t up_ch;
	op_idx_t up_op;
	logic [1:0] mode;
	logic [5:0] eff_lat;
	fnum_t fnum_ch3op1, fnum_ch3op2, fnum_ch3op3;
	block_t block_ch3op1, block_ch3op2, block_ch3op3;

	// writes during busy are dropped
	assign wr_data = cpu_wr && cpu_a0 && !busy;
	assign lo_ok = addr_q[1:0] != 2'd3;
	assign in_op = addr_q >= 8'h30 && addr_q <= 8'h9F;

	// order matches the up_* ports below
	always_comb begin
		up_next = '0;
		up_next[11] = !part_q && addr_q == 8'h28;
		up_next[10] = lo_ok && addr_q[7:2] == 6'b101100;
		up_next[9] = lo_ok && addr_q[7:2] == 6'b101001;
		up_next[8] = lo_ok && addr_q[7:2] == 6'b101000;
		up_next[7] = lo_ok && addr_q[7:2] == 6'b101101;
		if (in_op && lo_ok) begin
			case (addr_q[7:4])
				4'h3: up_next[6] = 1'b1;
				4'h4: up_next[5] = 1'b1;
				4'h5: up_next[4] = 1'b1;
				4'h6: up_next[3] = 1'b1;
				4'h7: up_next[2] = 1'b1;
				4'h8: up_next[1] = 1'b1;
				default: up_next[0] = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			addr_q <= '0;
			part_q <= 1'b0;
			up_q <= '0;
			up_din <= '0;
			up_ch <= '0;
			up_op <= '0;
			mode <= 2'b00;
			eff_lat <= '0;
			fnum_ch3op1 <= '0;
			fnum_ch3op2 <= '0;
			fnum_ch3op3 <= '0;
			block_ch3op1 <= '0;
			block_ch3op2 <= '0;
			block_ch3op3 <= '0;
		end else if (clk_en) begin
			// strobe lasts until the slot block has seen one tick of it
			up_q <= '0;
			if (cpu_wr && !cpu_a0) begin
				addr_q <= cpu_din;
				part_q <= cpu_part;
			end
			if (wr_data) begin
				up_q <= up_next;
				up_din <= cpu_din;
				up_ch <= {part_q, addr_q[1:0]};
				up_op <= addr_q[3:2];
				if (!part_q && addr_q == 8'h27) begin
					mode <= cpu_din[7:6];
				end
				// channel 3 effect, A8 is S3, A9 is S1, AA is S2
				if (!part_q && lo_ok && addr_q[7:2] == 6'b101011) begin
					eff_lat <= cpu_din[5:0];
				end
				if (!part_q && lo_ok && addr_q[7:2] == 6'b101010) begin
					case (addr_q[1:0])
						2'd0: begin
							fnum_ch3op3 <= {eff_lat[2:0], cpu_din};
							block_ch3op3 <= eff_lat[5:3];
						end
						2'd1: begin
							fnum_ch3op1 <= {eff_lat[2:0], cpu_din};
							block_ch3op1 <= eff_lat[5:3];
						end
						default: begin
							fnum_ch3op2 <= {eff_lat[2:0], cpu_din};
							block_ch3op2 <= eff_lat[5:3];
						end
					endcase
				end
			end
		end
	end

	fm_slot_regs u_slot_regs (
		.clk            (clk),
		.rst            (rst),
		.clk_en         (clk_en),
		.din            (up_din),
		.ch             (up_ch),
		.op             (up_op),
		.up_keyon       (up_q[11]),
		.up_alg         (up_q[10]),
		.up_block       (up_q[9]),
		.up_fnumlo      (up_q[8]),
		.up_pms         (up_q[7]),
		.up_dt1         (up_q[6]),
		.up_tl          (up_q[5]),
		.up_ks_ar       (up_q[4]),
		.up_amen_d1r    (up_q[3]),
		.up_d2r         (up_q[2]),
		.up_d1l         (up_q[1]),
		.up_ssgeg       (up_q[0]),
		.effect         (mode[1] | mode[0]),
		.csm            (mode[1]),
		.overflow_a     (overflow_a),
		.fnum_ch3op1    (fnum_ch3op1),
		.fnum_ch3op2    (fnum_ch3op2),
		.fnum_ch3op3    (fnum_ch3op3),
		.block_ch3op1   (block_ch3op1),
		.block_ch3op2   (block_ch3op2),
		.block_ch3op3   (block_ch3op3),
		.busy           (busy),
		.zero           (zero),
		.ch6op          (ch6op),
		.s1_enters      (s1_enters),
		.s2_enters      (s2_enters),
		.s3_enters      (s3_enters),
		.s4_enters      (s4_enters),
		.fnum           (fnum),
		.block          (block),
		.rl             (rl),
		.fb             (fb),
		.alg            (alg),
		.pms            (pms),
		.ams            (ams),
		.amsen          (amsen),
		.dt1            (dt1),
		.mul            (mul),
		.tl             (tl),
		.ks             (ks),
		.ar             (ar),
		.d1r            (d1r),
		.d2r            (d2r),
		.rr             (rr),
		.d1l            (d1l),
		.ssg_en         (ssg_en),
		.ssg_eg         (ssg_eg),
		.keyon          (keyon),
		.use_prev1      (use_prev1),
		.use_prev2      (use_prev2),
		.use_prevprev1  (use_prevprev1),
		.use_internal_x (use_internal_x),
		.use_internal_y (use_internal_y)
	);

endmodule

`default_nettype wire

// ==== hw/fm_op_ram.sv ====
`default_nettype none

module fm_op_ram import fm_pkg::*; (
	input  logic                 clk,
	input  logic                 clk_en,
	input  slot_t                wr_addr,
	input  slot_t                rd_addr,
	input  logic [OP_WORD_W-1:0] data,
	output logic [OP_WORD_W-1:0] q
);

	logic [OP_WORD_W-1:0] mem [32];

	// every tick writes back the current slot and reads the next one
	always_ff @(posedge clk) begin
		if (clk_en) begin
			mem[wr_addr] <= data;
			q <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

// ==== hw/fm_pkg.sv ====
`default_nettype none

package fm_pkg;

	// operator position in processing order: 0 S1, 1 S3, 2 S2, 3 S4
	typedef logic [1:0] op_idx_t;

	// channel index, bank in the top bit (3 and 7 unused)
	typedef logic [2:0] ch_idx_t;

	// {operator, channel}
	typedef logic [4:0] slot_t;

	typedef logic [10:0] fnum_t;
	typedef logic [2:0] block_t;
	typedef logic [2:0] alg_t;
	typedef logic [7:0] reg_byte_t;

	localparam int NUM_SLOTS = 24;

	// tl 7, dt1 3, mul 4, ks 2, ar 5, amsen 1, d1r 5, d2r 5, d1l 4, rr 4,
	// ssg_en 1, ssg_eg 3
	localparam int OP_WORD_W = 44;

	// latched block/fnum-high 6, block/fnum 14, fb/alg 6, ams/pms 5
	localparam int CH_WORD_W = 31;

	// one stage per channel, so a full pass is one channel lap
	localparam int CH_STAGES = 6;

	// S4 on channel 6, the counter wraps after this one
	localparam slot_t LAST_SLOT = {2'd3, 3'd6};

	// operator RAM clearing after reset
	typedef enum logic {
		INIT,
		RUN
	} slot_phase_t;

endpackage

`default_nettype wire

// ==== hw/fm_slot_regs.sv ====
`default_nettype none

module fm_slot_regs import fm_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      clk_en,
	input  reg_byte_t din,
	input  ch_idx_t   ch,
	input  op_idx_t   op,
	input  logic      up_keyon,
	input  logic      up_alg,
	input  logic      up_block,
	input  logic      up_fnumlo,
	input  logic      up_pms,
	input  logic      up_dt1,
	input  logic      up_tl,
	input  logic      up_ks_ar,
	input  logic      up_amen_d1r,
	input  logic      up_d2r,
	input  logic      up_d1l,
	input  logic      up_ssgeg,
	input  logic      effect,
	input  logic      csm,
	input  logic      overflow_a,
	input  fnum_t     fnum_ch3op1,
	input  fnum_t     fnum_ch3op2,
	input  fnum_t     fnum_ch3op3,
	input  block_t    block_ch3op1,
	input  block_t    block_ch3op2,
	input  block_t    block_ch3op3,
	output logic      busy,
	output logic      zero,
	output logic      ch6op,
	output logic      s1_enters,
	output logic      s2_enters,
	output logic      s3_enters,
	output logic      s4_enters,
	output fnum_t     fnum,
	output block_t    block,
	output logic [1:0] rl,
	output logic [2:0] fb,
	output alg_t      alg,
	output logic [2:0] pms,
	output logic [1:0] ams,
	output logic      amsen,
	output logic [2:0] dt1,
	output logic [3:0] mul,
	output logic [6:0] tl,
	output logic [1:0] ks,
	output logic [4:0] ar,
	output logic [4:0] d1r,
	output logic [4:0] d2r,
	output logic [3:0] rr,
	output logic [3:0] d1l,
	output logic      ssg_en,
	output logic [2:0] ssg_eg,
	output logic      keyon,
	output logic      use_prev1,
	output logic      use_prev2,
	output logic      use_prevprev1,
	output logic      use_internal_x,
	output logic      use_internal_y
);

	op_idx_t cur_op;
	ch_idx_t cur_ch;
	slot_t cur_slot, next_slot, lap_slot;
	slot_phase_t phase;
	logic busy_lap;

	logic [11:0] up_vec, pend;
	logic p_keyon, p_alg, p_block, p_fnumlo, p_pms, p_dt1;
	logic p_tl, p_ks_ar, p_amen_d1r, p_d2r, p_d1l, p_ssgeg;
	reg_byte_t pend_din;
	ch_idx_t pend_ch;
	op_idx_t pend_op;
	logic op_hit, ch_hit;

	assign cur_slot = {cur_op, cur_ch};
	assign zero = cur_slot == '0;
	assign ch6op = cur_ch == 3'd6;
	assign s1_enters = cur_op == 2'd0;
	assign s3_enters = cur_op == 2'd1;
	assign s2_enters = cur_op == 2'd2;
	assign s4_enters = cur_op == 2'd3;

	// channel skips 3 and 7, operator steps after channel 6
	always_comb begin
		if (cur_slot == LAST_SLOT) begin
			next_slot = '0;
		end else begin
			next_slot[4:3] = (cur_ch == 3'd6) ? cur_op + 2'd1 : cur_op;
			next_slot[2:0] = (cur_ch[1:0] == 2'd2) ? cur_ch + 3'd2 : cur_ch + 3'd1;
		end
	end

	assign up_vec = {up_keyon, up_alg, up_block, up_fnumlo, up_pms, up_dt1,
		up_tl, up_ks_ar, up_amen_d1r, up_d2r, up_d1l, up_ssgeg};
	assign {p_keyon, p_alg, p_block, p_fnumlo, p_pms, p_dt1,
		p_tl, p_ks_ar, p_amen_d1r, p_d2r, p_d1l, p_ssgeg} = pend;

	assign busy = busy_lap | (|up_vec) | (phase == INIT);

	always_ff @(posedge clk) begin
		if (rst) begin
			cur_op <= '0;
			cur_ch <= '0;
			phase <= INIT;
			busy_lap <= 1'b0;
			pend <= '0;
		end else if (clk_en) begin
			{cur_op, cur_ch} <= next_slot;
			if (phase == INIT && cur_slot == LAST_SLOT) begin
				phase <= RUN;
			end
			// a write stays pending for one lap from its arrival slot
			if (|up_vec) begin
				busy_lap <= 1'b1;
				pend <= up_vec;
			end else if (busy_lap && cur_slot == lap_slot) begin
				busy_lap <= 1'b0;
				pend <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (clk_en && |up_vec) begin
			lap_slot <= cur_slot;
			pend_din <= din;
			pend_ch <= ch;
			pend_op <= op;
		end
	end

	assign op_hit = {pend_op, pend_ch} == cur_slot;
	assign ch_hit = pend_ch == cur_ch;

	// operator word
	logic [OP_WORD_W-1:0] op_q, op_d;
	logic [6:0] q_tl;
	logic [2:0] q_dt1;
	logic [3:0] q_mul;
	logic [1:0] q_ks;
	logic [4:0] q_ar;
	logic q_amsen;
	logic [4:0] q_d1r;
	logic [4:0] q_d2r;
	logic [3:0] q_d1l;
	logic [3:0] q_rr;
	logic q_ssg_en;
	logic [2:0] q_ssg_eg;

	assign {q_tl, q_dt1, q_mul, q_ks, q_ar, q_amsen, q_d1r, q_d2r,
		q_d1l, q_rr, q_ssg_en, q_ssg_eg} = op_q;

	assign tl = (p_tl && op_hit) ? pend_din[6:0] : q_tl;
	assign dt1 = (p_dt1 && op_hit) ? pend_din[6:4] : q_dt1;
	assign mul = (p_dt1 && op_hit) ? pend_din[3:0] : q_mul;
	assign ks = (p_ks_ar && op_hit) ? pend_din[7:6] : q_ks;
	assign ar = (p_ks_ar && op_hit) ? pend_din[4:0] : q_ar;
	assign amsen = (p_amen_d1r && op_hit) ? pend_din[7] : q_amsen;
	assign d1r = (p_amen_d1r && op_hit) ? pend_din[4:0] : q_d1r;
	assign d2r = (p_d2r && op_hit) ? pend_din[4:0] : q_d2r;
	assign d1l = (p_d1l && op_hit) ? pend_din[7:4] : q_d1l;
	assign rr = (p_d1l && op_hit) ? pend_din[3:0] : q_rr;
	assign ssg_en = (p_ssgeg && op_hit) ? pend_din[3] : q_ssg_en;
	assign ssg_eg = (p_ssgeg && op_hit) ? pend_din[2:0] : q_ssg_eg;

	assign op_d = {tl, dt1, mul, ks, ar, amsen, d1r, d2r, d1l, rr, ssg_en, ssg_eg};

	fm_op_ram u_op_ram (
		.clk     (clk),
		.clk_en  (clk_en),
		.wr_addr (cur_slot),
		.rd_addr (next_slot),
		.data    ((phase == INIT) ? '0 : op_d),
		.q       (op_q)
	);

	// channel word, block/fnum-high waits in its latch for the low byte
	logic [CH_WORD_W-1:0] ch_q, ch_d;
	logic [5:0] lat_q, lat_d;
	logic [13:0] bf_q, bf_d;
	logic [5:0] fbalg_q, fbalg_d;
	logic [4:0] ampm_q, ampm_d;
	logic [1:0] rl_q;
	fnum_t fnum_raw;
	block_t block_raw;

	assign {lat_q, bf_q, fbalg_q, ampm_q} = ch_q;

	assign lat_d = (p_block && ch_hit) ? pend_din[5:0] : lat_q;
	assign bf_d = (p_fnumlo && ch_hit) ? {lat_q, pend_din} : bf_q;
	assign fbalg_d = (p_alg && ch_hit) ? pend_din[5:0] : fbalg_q;
	assign ampm_d = (p_pms && ch_hit) ? {pend_din[5:4], pend_din[2:0]} : ampm_q;
	assign rl = (p_pms && ch_hit) ? pend_din[7:6] : rl_q;

	assign ch_d = {lat_d, bf_d, fbalg_d, ampm_d};
	assign {block_raw, fnum_raw} = bf_d;
	assign {fb, alg} = fbalg_d;
	assign {ams, pms} = ampm_d;

	fm_ch_shreg #(.width(CH_WORD_W), .stages(CH_STAGES), .rst_val('0)) u_ch_word (
		.clk    (clk),
		.clk_en (clk_en),
		.rst    (rst),
		.din    (ch_d),
		.dout   (ch_q)
	);

	// both outputs enabled after reset
	fm_ch_shreg #(.width(2), .stages(CH_STAGES), .rst_val(2'b11)) u_ch_rl (
		.clk    (clk),
		.clk_en (clk_en),
		.rst    (rst),
		.din    (rl),
		.dout   (rl_q)
	);

	// channel 3 effect mode, S4 keeps the channel frequency
	always_comb begin
		fnum = fnum_raw;
		block = block_raw;
		if (effect && cur_ch == 3'd2) begin
			case (cur_op)
				2'd0: begin
					fnum = fnum_ch3op1;
					block = block_ch3op1;
				end
				2'd1: begin
					fnum = fnum_ch3op3;
					block = block_ch3op3;
				end
				2'd2: begin
					fnum = fnum_ch3op2;
					block = block_ch3op2;
				end
				default: ;
			endcase
		end
	end

	fm_keyon u_keyon (
		.clk        (clk),
		.rst        (rst),
		.clk_en     (clk_en),
		.keyon_op   (pend_din[7:4]),
		.keyon_ch   (pend_din[2:0]),
		.cur_op     (cur_op),
		.cur_ch     (cur_ch),
		.up_keyon   (p_keyon),
		.csm        (csm),
		.overflow_a (overflow_a),
		.keyon      (keyon)
	);

	fm_alg_route u_alg_route (
		.alg            (alg),
		.s1_enters      (s1_enters),
		.s2_enters      (s2_enters),
		.s3_enters      (s3_enters),
		.s4_enters      (s4_enters),
		.use_prev1      (use_prev1),
		.use_prev2      (use_prev2),
		.use_prevprev1  (use_prevprev1),
		.use_internal_x (use_internal_x),
		.use_internal_y (use_internal_y)
	);

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+bench
hw/fm_pkg.sv
hw/fm_op_ram.sv
hw/fm_ch_shreg.sv
hw/fm_keyon.sv
hw/fm_alg_route.sv
hw/fm_slot_regs.sv
hw/fm_mmr.sv
bench/tb_fm_mmr.sv
